//--- project.f
source/mipsIsaPkg.sv
source/datapathPkg.sv
source/InstDecoder.sv
source/RegFile.sv
source/DecodeStage.sv
source/ExecuteStage.sv
source/ExecCore.sv
dv/ClockGen.sv
dv/ExecCore_asserts.sv
dv/ExecCoreTb.sv

//--- dv/ExecCoreTb.sv
`timescale 1ns/10ps

module ExecCoreTb import mipsIsaPkg::*; ();

	localparam int clkPeriodNs = 20;
	localparam wordT basePc = 32'h0040_0000;

	typedef struct packed {
		wordT word;
		wordT pc;
		logic expWr;
		regAddrT expDst;
		wordT expData;
		logic [1:0] gap;
	} rowS;

	logic clk;
	logic rstN;
	logic instValid;
	wordT instWord;
	wordT instPc;
	logic wbValid;
	regAddrT wbDst;
	wordT wbData;

	rowS rowsQ[$];
	// row index per cycle still in the pipeline or -1 for idle
	int inFlight[$];
	integer seed;
	logic tableReady = 1'b0;
	int checkCount = 0;
	int errCount = 0;
	int rowsOk = 0;
	int rowsBad = 0;

	ClockGen clockGen_i (
		.clk(clk),
		.rstN(rstN)
	);

	ExecCore dut_i (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.instWord(instWord),
		.instPc(instPc),
		.wbValid(wbValid),
		.wbDst(wbDst),
		.wbData(wbData)
	);

	function automatic wordT encodeR(input functE fn, input regAddrT rs, input regAddrT rt,
			input regAddrT rd, input logic [4:0] sh);
		return {opSpecial, rs, rt, rd, sh, fn};
	endfunction

	function automatic wordT encodeI(input opcodeE op, input regAddrT rs, input regAddrT rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic int randomGap();
		return $unsigned($random(seed)) % 3;
	endfunction

	function automatic void addRow(input wordT word, input logic expWr, input regAddrT expDst,
			input wordT expData, input int gap);
		rowsQ.push_back(rowS'{word, basePc + 4 * rowsQ.size(), expWr, expDst, expData, 2'(gap)});
	endfunction

	function automatic void fillTable();
		logic [15:0] randA;
		logic [15:0] randB;
		wordT linkVal;
		wordT valA;
		wordT valB;
		randA = $random(seed);
		randB = $random(seed);
		// r1 = 5, r2 = -3
		addRow(encodeI(opAddiu, 5'd0, 5'd1, 16'h0005), 1'b1, 5'd1, 32'h0000_0005, randomGap());
		addRow(encodeI(opAddiu, 5'd0, 5'd2, 16'hfffd), 1'b1, 5'd2, 32'hffff_fffd, 0);
		addRow(encodeR(fnAddu, 5'd1, 5'd2, 5'd3, 5'd0), 1'b1, 5'd3, 32'h0000_0002, 0);
		addRow(encodeR(fnSubu, 5'd1, 5'd2, 5'd4, 5'd0), 1'b1, 5'd4, 32'h0000_0008, 0);
		addRow(encodeR(fnSlt, 5'd2, 5'd1, 5'd5, 5'd0), 1'b1, 5'd5, 32'h0000_0001, 0);
		addRow(encodeR(fnSlt, 5'd1, 5'd2, 5'd6, 5'd0), 1'b1, 5'd6, 32'h0000_0000, 0);
		// 5 < -2 is false only with a sign-extended immediate
		addRow(encodeI(opSlti, 5'd1, 5'd26, 16'hfffe), 1'b1, 5'd26, 32'h0000_0000, 0);
		addRow(encodeI(opAddiu, 5'd0, 5'd7, 16'h00f0), 1'b1, 5'd7, 32'h0000_00f0, randomGap());
		addRow(encodeI(opOri, 5'd0, 5'd8, 16'h0ff0), 1'b1, 5'd8, 32'h0000_0ff0, randomGap());
		addRow(encodeR(fnAnd, 5'd7, 5'd8, 5'd9, 5'd0), 1'b1, 5'd9, 32'h0000_00f0, 0);
		addRow(encodeR(fnOr, 5'd7, 5'd8, 5'd10, 5'd0), 1'b1, 5'd10, 32'h0000_0ff0, 0);
		addRow(encodeR(fnXor, 5'd7, 5'd8, 5'd11, 5'd0), 1'b1, 5'd11, 32'h0000_0f00, 0);
		addRow(encodeR(fnSll, 5'd0, 5'd1, 5'd12, 5'd4), 1'b1, 5'd12, 32'h0000_0050, 0);
		addRow(encodeI(opLui, 5'd0, 5'd13, 16'h8001), 1'b1, 5'd13, 32'h8001_0000, randomGap());
		addRow(encodeI(opAndi, 5'd2, 5'd14, 16'hff0f), 1'b1, 5'd14, 32'h0000_ff0d, 0);
		// r13 comes from two rows back
		addRow(encodeI(opOri, 5'd13, 5'd15, 16'h9234), 1'b1, 5'd15, 32'h8001_9234, 0);
		addRow(encodeI(opSlti, 5'd2, 5'd16, 16'hfffe), 1'b1, 5'd16, 32'h0000_0001, 0);
		addRow(encodeR(fnAddu, 5'd16, 5'd16, 5'd17, 5'd0), 1'b1, 5'd17, 32'h0000_0002, 0);
		addRow(encodeR(fnSubu, 5'd17, 5'd4, 5'd18, 5'd0), 1'b1, 5'd18, 32'hffff_fffa, 0);
		linkVal = basePc + 4 * rowsQ.size() + 8;
		addRow({opJal, 26'h010_0040}, 1'b1, 5'd31, linkVal, randomGap());
		addRow(encodeR(fnAddu, 5'd31, 5'd0, 5'd19, 5'd0), 1'b1, 5'd19, linkVal, 0);
		// write to r0 is dropped and r0 still reads zero
		addRow(encodeI(opAddiu, 5'd1, 5'd0, 16'h0007), 1'b0, 5'd0, 32'h0, 0);
		addRow(encodeR(fnAddu, 5'd0, 5'd1, 5'd20, 5'd0), 1'b1, 5'd20, 32'h0000_0005, 0);
		addRow(32'hfc00_0000, 1'b0, 5'd0, 32'h0, randomGap());
		addRow({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h3f}, 1'b0, 5'd0, 32'h0, 0);
		// r3 must still hold its value after the unknown encoding aimed at it
		addRow(encodeR(fnAddu, 5'd20, 5'd3, 5'd21, 5'd0), 1'b1, 5'd21, 32'h0000_0007, randomGap());
		valA = {16'h0000, randA};
		valB = {{16{randB[15]}}, randB};
		addRow(encodeI(opOri, 5'd0, 5'd22, randA), 1'b1, 5'd22, valA, randomGap());
		addRow(encodeI(opAddiu, 5'd0, 5'd23, randB), 1'b1, 5'd23, valB, 0);
		addRow(encodeR(fnXor, 5'd22, 5'd23, 5'd24, 5'd0), 1'b1, 5'd24, valA ^ valB, 0);
		addRow(encodeR(fnSll, 5'd0, 5'd24, 5'd25, 5'd31), 1'b1, 5'd25, (valA ^ valB) << 31, 0);
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errCount++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
		end
	endtask

	task automatic checkSlot(input int idx);
		int errBefore;
		rowS entry;
		errBefore = errCount;
		if (idx < 0) begin
			checkValue("wbValid in idle cycle", wbValid, 32'd0);
		end else begin
			entry = rowsQ[idx];
			checkValue($sformatf("row %0d wbValid", idx), wbValid, entry.expWr);
			if (entry.expWr) begin
				checkValue($sformatf("row %0d wbDst", idx), wbDst, entry.expDst);
				checkValue($sformatf("row %0d wbData", idx), wbData, entry.expData);
			end
			if (errCount == errBefore) begin
				rowsOk++;
			end else begin
				rowsBad++;
			end
			$display("row %2d word %h: %s", idx, entry.word,
				(errCount == errBefore) ? "ok" : "mismatch");
		end
	endtask

	// called just after a falling edge
	task automatic runCycle(input int idx);
		if (inFlight.size() == 2) begin
			checkSlot(inFlight.pop_front());
		end
		if (idx < 0) begin
			instValid = 1'b0;
			instWord = $random(seed);
			instPc = '0;
		end else begin
			instValid = 1'b1;
			instWord = rowsQ[idx].word;
			instPc = rowsQ[idx].pc;
		end
		inFlight.push_back(idx);
		@(negedge clk);
	endtask

	initial begin
		instValid = 1'b0;
		instWord = '0;
		instPc = '0;
		seed = 32'h3053_f2eb;
		fillTable();
		tableReady = 1'b1;
		wait (rstN === 1'b1);
		repeat (4) runCycle(-1);
		foreach (rowsQ[i]) begin
			repeat (rowsQ[i].gap) runCycle(-1);
			runCycle(i);
		end
		// drain the last two rows
		repeat (2) runCycle(-1);
		$display("summary: %0d rows ok, %0d rows bad, %0d checks, %0d errors, %0d assertion failures",
			rowsOk, rowsBad, checkCount, errCount, dut_i.asserts_i.failCount);
		if (errCount == 0 && dut_i.asserts_i.failCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		wait (tableReady);
		#((rowsQ.size() * 4 + 20) * clkPeriodNs);
		$display("timeout: the run did not finish within %0d clock cycles", rowsQ.size() * 4 + 20);
		$display("Regression failed");
		$finish;
	end

endmodule

//--- dv/ExecCore_asserts.sv
`timescale 1ns/10ps

module ExecCoreAsserts import mipsIsaPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input logic wbValid,
	input regAddrT wbDst
);

	int failCount = 0;

	wbValidKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(wbValid))
	else begin
		failCount++;
		$error("wbValid is unknown after reset");
	end

	wbDstNonZero: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> wbDst != '0)
	else begin
		failCount++;
		$error("writeback reported for register 0");
	end

	// two stages between the input strobe and the writeback port
	wbFromInst: assert property (@(posedge clk) disable iff (!rstN) wbValid |-> $past(instValid, 2))
	else begin
		failCount++;
		$error("writeback without an instruction two cycles earlier");
	end

endmodule

bind ExecCore ExecCoreAsserts asserts_i (
	.clk(clk),
	.rstN(rstN),
	.instValid(instValid),
	.wbValid(wbValid),
	.wbDst(wbDst)
);

//--- dv/ClockGen.sv
`timescale 1ns/10ps

module ClockGen (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// reset spans two rising edges and lifts on a falling edge
	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

//--- source/ExecCore.sv
`timescale 1ns/10ps

module ExecCore import mipsIsaPkg::*, datapathPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input wordT instWord,
	input wordT instPc,
	output logic wbValid,
	output regAddrT wbDst,
	output wordT wbData
);

	regAddrT rdAddrA;
	regAddrT rdAddrB;
	wordT rdDataA;
	wordT rdDataB;
	idExS idEx;
	exWbS exWb;

	DecodeStage decode_i (
		.clk(clk),
		.rstN(rstN),
		.instValid(instValid),
		.instWord(instWord),
		.instPc(instPc),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.idEx(idEx)
	);

	RegFile regFile_i (
		.clk(clk),
		.rstN(rstN),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB),
		.wb(exWb)
	);

	ExecuteStage execute_i (
		.clk(clk),
		.rstN(rstN),
		.idEx(idEx),
		.exWb(exWb)
	);

	// writeback port mirrors the register file write
	assign wbValid = exWb.valid && exWb.wrEn;
	assign wbDst = exWb.dst;
	assign wbData = exWb.data;

endmodule

//--- source/ExecuteStage.sv
`timescale 1ns/10ps

module ExecuteStage import mipsIsaPkg::*, datapathPkg::*; (
	input logic clk,
	input logic rstN,
	input idExS idEx,
	output exWbS exWb
);

	logic fwdOk;
	// bit 1 forwards operand A, bit 0 operand B
	logic [1:0] fwdSel;
	wordT opA;
	wordT opB;
	wordT aluA;
	wordT aluB;
	wordT aluRes;
	wordT wbData;

	// only one source to forward from, the instruction now in writeback
	assign fwdOk = exWb.valid && exWb.wrEn && (exWb.dst != '0);
	assign fwdSel[1] = fwdOk && (exWb.dst == idEx.rs);
	assign fwdSel[0] = fwdOk && (exWb.dst == idEx.rt);

	assign opA = fwdSel[1] ? exWb.data : idEx.rsVal;
	assign opB = fwdSel[0] ? exWb.data : idEx.rtVal;

	assign aluA = idEx.ctrl.aFromImm ? idEx.imm : opA;
	assign aluB = idEx.ctrl.bFromImm ? idEx.imm : opB;

	always_comb begin
		case (idEx.ctrl.aluOp)
			addOp: begin
				aluRes = aluA + aluB;
			end
			subOp: begin
				aluRes = aluA - aluB;
			end
			andOp: begin
				aluRes = aluA & aluB;
			end
			orOp: begin
				aluRes = aluA | aluB;
			end
			xorOp: begin
				aluRes = aluA ^ aluB;
			end
			sltOp: begin
				aluRes = {31'd0, $signed(aluA) < $signed(aluB)};
			end
			sllOp: begin
				aluRes = aluB << aluA[4:0];
			end
			default: begin
				aluRes = '0;
			end
		endcase
	end

	assign wbData = (idEx.ctrl.wbSel == linkWb) ? idEx.linkAddr : aluRes;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exWb <= '0;
		end else begin
			exWb.valid <= idEx.valid;
			// a write to register 0 is dropped here
			exWb.wrEn <= idEx.valid && idEx.ctrl.wrEn && (idEx.dst != '0);
			exWb.dst <= idEx.dst;
			exWb.data <= wbData;
		end
	end

endmodule

//--- source/DecodeStage.sv
`timescale 1ns/10ps

module DecodeStage import mipsIsaPkg::*, datapathPkg::*; (
	input logic clk,
	input logic rstN,
	input logic instValid,
	input wordT instWord,
	input wordT instPc,
	output regAddrT rdAddrA,
	output regAddrT rdAddrB,
	input wordT rdDataA,
	input wordT rdDataB,
	output idExS idEx
);

	rTypeS rInst;
	iTypeS iInst;
	ctrlS ctrl;
	logic known;
	wordT extImm;
	regAddrT dst;

	assign rInst = rTypeS'(instWord);
	assign iInst = iTypeS'(instWord);

	InstDecoder decoder_i (
		.instWord(instWord),
		.ctrl(ctrl),
		.known(known)
	);

	assign rdAddrA = rInst.rs;
	assign rdAddrB = rInst.rt;

	always_comb begin
		case (ctrl.extMode)
			signExt: extImm = {{16{iInst.imm[15]}}, iInst.imm};
			zeroExt: extImm = {16'h0000, iInst.imm};
			shamtExt: extImm = {27'd0, rInst.shamt};
			default: extImm = {iInst.imm, 16'h0000};
		endcase
	end

	always_comb begin
		case (ctrl.dstSel)
			rdDst: dst = rInst.rd;
			linkDst: dst = linkRegC;
			default: dst = rInst.rt;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			idEx <= '0;
		end else begin
			// unknown encodings enter as bubbles
			idEx.valid <= instValid && known;
			idEx.ctrl <= ctrl;
			idEx.rs <= rInst.rs;
			idEx.rt <= rInst.rt;
			idEx.rsVal <= rdDataA;
			idEx.rtVal <= rdDataB;
			idEx.imm <= extImm;
			idEx.dst <= dst;
			idEx.linkAddr <= instPc + 32'd8;
		end
	end

endmodule

//--- source/RegFile.sv
`timescale 1ns/10ps

module RegFile import mipsIsaPkg::*, datapathPkg::*; (
	input logic clk,
	input logic rstN,
	input regAddrT rdAddrA,
	input regAddrT rdAddrB,
	output wordT rdDataA,
	output wordT rdDataB,
	input exWbS wb
);

	// register 0 has no storage
	wordT regs [1:31];
	logic wrHit;

	assign wrHit = wb.valid && wb.wrEn && (wb.dst != '0);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrHit) begin
			regs[wb.dst] <= wb.data;
		end
	end

	function automatic wordT readPort(input regAddrT addr);
		if (addr == '0) begin
			return '0;
		end
		// write-through for a same cycle read of the target
		if (wrHit && (addr == wb.dst)) begin
			return wb.data;
		end
		return regs[addr];
	endfunction

	always_comb begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

endmodule

//--- source/InstDecoder.sv
`timescale 1ns/10ps

module InstDecoder import mipsIsaPkg::*, datapathPkg::*; (
	input wordT instWord,
	output ctrlS ctrl,
	output logic known
);

	rTypeS inst;

	assign inst = rTypeS'(instWord);

	always_comb begin
		// defaults describe a bubble that writes nothing
		ctrl.extMode = signExt;
		ctrl.dstSel = rtDst;
		ctrl.aluOp = addOp;
		ctrl.aFromImm = 1'b0;
		ctrl.bFromImm = 1'b0;
		ctrl.wbSel = aluWb;
		ctrl.wrEn = 1'b0;
		known = 1'b0;

		case (opcodeE'(inst.opcode))
			opSpecial: begin
				ctrl.dstSel = rdDst;
				known = 1'b1;
				ctrl.wrEn = 1'b1;
				case (functE'(inst.funct))
					fnAddu: ctrl.aluOp = addOp;
					fnSubu: ctrl.aluOp = subOp;
					fnAnd: ctrl.aluOp = andOp;
					fnOr: ctrl.aluOp = orOp;
					fnXor: ctrl.aluOp = xorOp;
					fnSlt: ctrl.aluOp = sltOp;
					fnSll: begin
						// shift amount comes in on A, rt on B
						ctrl.aluOp = sllOp;
						ctrl.extMode = shamtExt;
						ctrl.aFromImm = 1'b1;
					end
					default: begin
						known = 1'b0;
						ctrl.wrEn = 1'b0;
					end
				endcase
			end
			opAddiu, opSlti: begin
				ctrl.extMode = signExt;
				ctrl.bFromImm = 1'b1;
				ctrl.aluOp = (opcodeE'(inst.opcode) == opSlti) ? sltOp : addOp;
				ctrl.wrEn = 1'b1;
				known = 1'b1;
			end
			opAndi, opOri: begin
				ctrl.extMode = zeroExt;
				ctrl.bFromImm = 1'b1;
				ctrl.aluOp = (opcodeE'(inst.opcode) == opOri) ? orOp : andOp;
				ctrl.wrEn = 1'b1;
				known = 1'b1;
			end
			opLui: begin
				// rs is register 0 here so the sum is the upper immediate
				ctrl.extMode = upperExt;
				ctrl.bFromImm = 1'b1;
				ctrl.aluOp = addOp;
				ctrl.wrEn = 1'b1;
				known = 1'b1;
			end
			opJal: begin
				ctrl.dstSel = linkDst;
				ctrl.wbSel = linkWb;
				ctrl.wrEn = 1'b1;
				known = 1'b1;
			end
			default: begin
				known = 1'b0;
			end
		endcase
	end

endmodule

//--- source/datapathPkg.sv
package datapathPkg;

	import mipsIsaPkg::*;

	// immediate extension modes
	typedef enum logic [1:0] {
		signExt,
		zeroExt,
		shamtExt,
		upperExt
	} extModeE;

	typedef enum logic [1:0] {
		rtDst,
		rdDst,
		linkDst
	} dstSelE;

	typedef enum logic [2:0] {
		addOp,
		subOp,
		andOp,
		orOp,
		xorOp,
		sltOp,
		sllOp
	} aluOpE;

	typedef enum logic {
		aluWb,
		linkWb
	} wbSelE;

	typedef struct packed {
		extModeE extMode;
		dstSelE dstSel;
		aluOpE aluOp;
		logic aFromImm;
		logic bFromImm;
		wbSelE wbSel;
		logic wrEn;
	} ctrlS;

	// decode to execute pipeline register
	typedef struct packed {
		logic valid;
		ctrlS ctrl;
		regAddrT rs;
		regAddrT rt;
		wordT rsVal;
		wordT rtVal;
		wordT imm;
		regAddrT dst;
		wordT linkAddr;
	} idExS;

	// execute to writeback pipeline register
	typedef struct packed {
		logic valid;
		logic wrEn;
		regAddrT dst;
		wordT data;
	} exWbS;

endpackage

//--- source/mipsIsaPkg.sv
package mipsIsaPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0] regAddrT;

	// primary opcodes of the supported subset
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJal = 6'h03,
		opAddiu = 6'h09,
		opSlti = 6'h0a,
		opAndi = 6'h0c,
		opOri = 6'h0d,
		opLui = 6'h0f
	} opcodeE;

	// function codes under opSpecial
	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnXor = 6'h26,
		fnSlt = 6'h2a
	} functE;

	// register format view of an instruction word
	typedef struct packed {
		logic [5:0] opcode;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeS;

	// immediate format view of the same word
	typedef struct packed {
		logic [5:0] opcode;
		regAddrT rs;
		regAddrT rt;
		logic [15:0] imm;
	} iTypeS;

	localparam regAddrT linkRegC = 5'd31;

endpackage
